/* cart_defs.svh */
// Bus widths, header addresses, region codes, quirk bit positions and gun defaults
`ifndef CART_DEFS_SVH
`define CART_DEFS_SVH

// Host download bus
`define CART_ADDR_W 25
`define CART_DATA_W 16

// Cartridge header layout
`define HDR_REGION_LO  25'h1F0
`define HDR_REGION_HI  25'h1F2
`define HDR_READY_ADDR 25'h200
`define ID_FIRST_ADDR  25'h182 // First serial-number word
`define ID_LOOKUP_ADDR 25'h18C // Serial complete, look it up

// Console region codes
`define REGION_JP 2'd0
`define REGION_US 2'd1
`define REGION_EU 2'd2

// Bit positions in the quirk vector
`define QUIRK_SRAM   0
`define QUIRK_EEPROM 1
`define QUIRK_NORAM  2
`define QUIRK_FIFO   3
`define QUIRK_PIER   4
`define QUIRK_SVP    5
`define QUIRK_FMBUSY 6
`define QUIRK_SCHAN  7

`define GUN_DELAY_DEFAULT 8'd44

`endif

/* cart_pkg.sv */
// Cartridge header helpers for byte swap, region letters and serial-number quirks
`include "cart_defs.svh"

package cart_pkg;

	function automatic logic [15:0] swap_bytes(input logic [15:0] w);
		return {w[7:0], w[15:8]};
	endfunction

	// One-hot {J, U, other valid}, zero when no letter
	function automatic logic [2:0] classify_letter(input logic [7:0] c);
		if (c == "J")
			return 3'b100;
		else if (c == "U")
			return 3'b010;
		else if (c >= "0" && c <= "Z")
			return 3'b001;
		return 3'b000;
	endfunction

	function automatic void lookup_quirks(input logic [63:0] id, output logic [7:0] quirk,
			output logic gun, output logic [7:0] delay);
		quirk = '0;
		gun = 1'b0;
		delay = `GUN_DELAY_DEFAULT;
		case (id)
			"T-081276", "T-81406 ", "T-081586", "T-81576 ",
			"T-81476 ": quirk[`QUIRK_SRAM] = 1'b1;
			"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
			"00004076", "T-12046 ", "T-12053 ", "G-4524  ": quirk[`QUIRK_EEPROM] = 1'b1;
			"T-113016": quirk[`QUIRK_NORAM] = 1'b1;   // Fake RAM check
			"T-89016 ": quirk[`QUIRK_FIFO] = 1'b1;
			"T-574023", "T-574013": quirk[`QUIRK_PIER] = 1'b1;
			"MK-1229 ", "G-7001  ": quirk[`QUIRK_SVP] = 1'b1;
			"T-35036 ", "T-25073 ", "MK-1137-": quirk[`QUIRK_FMBUSY] = 1'b1;
			"T-68???-": quirk[`QUIRK_SCHAN] = 1'b1;    // Literal question marks
			default: ;
		endcase
		// Light-gun type and sensor timing
		case (id)
			"MK-1533 ": delay = 8'd100;
			"T-95096-": {gun, delay} = {1'b1, 8'd52};
			"T-95136-": {gun, delay} = {1'b1, 8'd30};
			"MK-1658 ": delay = 8'd120;
			"T-081156": delay = 8'd126;
			default: ;
		endcase
	endfunction

endpackage

/* cheat_pkg.sv */
// Cheat record union and byte-offset to word-slot mapping
package cheat_pkg;

	// Same 128 bits seen as named fields or as host words
	typedef union packed {
		struct packed {
			logic [31:0] flags;
			logic [31:0] address;
			logic [31:0] compare;
			logic [31:0] replace;
		} fields;
		logic [7:0][15:0] words;
	} cheat_code_u;

	// Low word of each field arrives first
	function automatic logic [2:0] cheat_slot(input logic [3:0] offset);
		return {~offset[3], ~offset[2], offset[1]};
	endfunction

endpackage

/* dl_if.sv */
// Download bus interface with source and sink modports
`timescale 1ns/1ps
`include "cart_defs.svh"

interface dl_if;
	logic download;
	logic [7:0] index;
	logic wr;
	logic [`CART_ADDR_W-1:0] addr;
	logic [`CART_DATA_W-1:0] data;

	modport src (output download, index, wr, addr, data);
	modport snk (input download, index, wr, addr, data);
endinterface

/* dl_demux.sv */
// Host bus split into cartridge and code buses, download start/end pulses
`timescale 1ns/1ps
`include "cart_defs.svh"

module dl_demux (
	input  logic clk_sys,
	input  logic RESET,
	input  logic ioctl_download,
	input  logic [7:0] ioctl_index,
	input  logic ioctl_wr,
	input  logic [`CART_ADDR_W-1:0] ioctl_addr,
	input  logic [`CART_DATA_W-1:0] ioctl_data,
	dl_if.src cart,
	dl_if.src code,
	output logic dl_start,
	output logic dl_end
);
	logic code_sel;
	logic cart_dl_q;

	assign code_sel = &ioctl_index; // All ones selects cheat codes

	assign cart.download = ioctl_download & ~code_sel;
	assign cart.index = ioctl_index;
	assign cart.wr = ioctl_wr;
	assign cart.addr = ioctl_addr;
	assign cart.data = ioctl_data;

	assign code.download = ioctl_download & code_sel;
	assign code.index = ioctl_index;
	assign code.wr = ioctl_wr;
	assign code.addr = ioctl_addr;
	assign code.data = ioctl_data;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q <= 1'b0;
			dl_start <= 1'b0;
			dl_end <= 1'b0;
		end else begin
			cart_dl_q <= cart.download;
			dl_start <= cart.download & ~cart_dl_q;
			dl_end <= ~cart.download & cart_dl_q;
		end
	end
endmodule

/* rom_write_pacer.sv */
// ROM write toggle handshake, host wait and ROM size capture
`timescale 1ns/1ps
`include "cart_defs.svh"

module rom_write_pacer import cart_pkg::*; (
	input  logic clk_sys,
	input  logic RESET,
	dl_if.snk cart,
	input  logic dl_end,
	input  logic rom_wrack,
	output logic rom_wr,
	output logic ioctl_wait,
	output logic [`CART_ADDR_W-2:0] rom_addr,
	output logic [`CART_DATA_W-1:0] rom_wdata,
	output logic [`CART_ADDR_W-1:0] rom_sz
);
	// Memory is word addressed, image bytes arrive swapped
	assign rom_addr = cart.addr[`CART_ADDR_W-1:1];
	assign rom_wdata = swap_bytes(cart.data);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ioctl_wait <= 1'b0;
			rom_wr <= 1'b0;
		end else if (cart.download & cart.wr) begin
			ioctl_wait <= 1'b1;
			rom_wr <= ~rom_wr; // New request
		end else if (ioctl_wait && rom_wr == rom_wrack) begin
			ioctl_wait <= 1'b0;
		end
	end

	// Last address still held on the bus
	always_ff @(posedge clk_sys) begin
		if (dl_end)
			rom_sz <= cart.addr;
	end
endmodule

/* header_sniffer.sv */
// Region letter flags and header-ready level from the cartridge header
`timescale 1ns/1ps
`include "cart_defs.svh"

module header_sniffer import cart_pkg::*; (
	input  logic clk_sys,
	dl_if.snk cart,
	input  logic dl_start,
	input  logic dl_end,
	output logic hdr_j,
	output logic hdr_u,
	output logic hdr_e,
	output logic hdr_ready
);
	logic cart_wr;
	logic [2:0] cls_lo;
	logic [2:0] cls_hi;

	assign cart_wr = cart.download & cart.wr;
	assign cls_lo = classify_letter(cart.data[7:0]);
	assign cls_hi = classify_letter(cart.data[15:8]);

	// Sticky flags, fresh for every image
	always_ff @(posedge clk_sys) begin
		if (dl_start)
			{hdr_j, hdr_u, hdr_e} <= 3'b000;
		else if (cart_wr && cart.addr == `HDR_REGION_LO)
			{hdr_j, hdr_u, hdr_e} <= {hdr_j, hdr_u, hdr_e} | cls_lo | cls_hi;
		else if (cart_wr && cart.addr == `HDR_REGION_HI)
			{hdr_j, hdr_u, hdr_e} <= {hdr_j, hdr_u, hdr_e} | cls_lo; // Third letter only
	end

	always_ff @(posedge clk_sys) begin
		if (dl_start | dl_end)
			hdr_ready <= 1'b0;
		else if (cart_wr && cart.addr == `HDR_READY_ADDR)
			hdr_ready <= 1'b1; // Header fully passed
	end
endmodule

/* region_select.sv */
// Console region request from header flags or file extension index
`timescale 1ns/1ps
`include "cart_defs.svh"

module region_select (
	input  logic clk_sys,
	input  logic RESET,
	input  logic hdr_j,
	input  logic hdr_u,
	input  logic hdr_e,
	input  logic hdr_ready,
	input  logic [7:0] index,
	input  logic [1:0] region_mode,
	input  logic [1:0] region_priority,
	output logic [1:0] region_req,
	output logic region_set
);
	logic ready_q;
	logic ready_rise;
	logic ready_fall;
	logic [1:0] hdr_pick;

	assign ready_rise = hdr_ready & ~ready_q;
	assign ready_fall = ~hdr_ready & ready_q;

	// First present region in priority order, else the fallback
	always_comb begin
		case (region_priority)
			2'd0: hdr_pick = hdr_u ? `REGION_US : hdr_e ? `REGION_EU : hdr_j ? `REGION_JP : `REGION_US;
			2'd1: hdr_pick = hdr_e ? `REGION_EU : hdr_u ? `REGION_US : hdr_j ? `REGION_JP : `REGION_EU;
			2'd2: hdr_pick = hdr_u ? `REGION_US : hdr_j ? `REGION_JP : hdr_e ? `REGION_EU : `REGION_US;
			default: hdr_pick = hdr_j ? `REGION_JP : hdr_u ? `REGION_US : hdr_e ? `REGION_EU : `REGION_JP;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ready_q <= 1'b0;
			region_set <= 1'b0;
		end else begin
			ready_q <= hdr_ready;
			if (ready_rise && region_mode == 2'd1)
				region_set <= 1'b1;
			else if (ready_rise && region_mode == 2'd0)
				region_set <= |index; // Extension index, zero means none
			else if (ready_fall)
				region_set <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ready_rise && region_mode == 2'd1)
			region_req <= hdr_pick;
		else if (ready_rise && region_mode == 2'd0)
			region_req <= index[7:6];
	end
endmodule

/* cart_quirk_regs.sv */
// Serial-number capture and per-game quirk and light-gun registers
`timescale 1ns/1ps
`include "cart_defs.svh"

module cart_quirk_regs import cart_pkg::*; (
	input  logic clk_sys,
	input  logic RESET,
	dl_if.snk cart,
	input  logic dl_start,
	output logic [7:0] quirks,
	output logic gun_type,
	output logic [7:0] gun_delay
);
	logic cart_wr;
	logic [63:0] cart_id;
	logic [7:0] id_quirks;
	logic id_gun;
	logic [7:0] id_delay;

	assign cart_wr = cart.download & cart.wr;

	//////////////////////////////
	// Serial number, eight ASCII bytes
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			case (cart.addr)
				`ID_FIRST_ADDR:          cart_id[63:56] <= cart.data[15:8];
				`ID_FIRST_ADDR + 25'd2:  cart_id[55:40] <= swap_bytes(cart.data);
				`ID_FIRST_ADDR + 25'd4:  cart_id[39:24] <= swap_bytes(cart.data);
				`ID_FIRST_ADDR + 25'd6:  cart_id[23:8] <= swap_bytes(cart.data);
				`ID_FIRST_ADDR + 25'd8:  cart_id[7:0] <= cart.data[7:0]; // Last byte
				default: ;
			endcase
		end
	end

	always_comb begin
		lookup_quirks(cart_id, id_quirks, id_gun, id_delay);
	end

	//////////////////////////////
	// Core configuration
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			quirks <= '0;
			gun_type <= 1'b0;
			gun_delay <= `GUN_DELAY_DEFAULT;
		end else if (dl_start) begin
			quirks <= '0;
		end else if (cart_wr && cart.addr == `ID_LOOKUP_ADDR) begin
			quirks <= quirks | id_quirks;
			gun_type <= id_gun;
			gun_delay <= id_delay; // Default unless a gun title
		end
	end
endmodule

/* cheat_loader.sv */
// Cheat record assembly from code download words
`timescale 1ns/1ps

module cheat_loader import cheat_pkg::*; (
	input  logic clk_sys,
	input  logic RESET,
	dl_if.snk code,
	output cheat_code_u gg_code,
	output logic gg_valid,
	output logic gg_reset
);
	logic code_wr;

	assign code_wr = code.download & code.wr;

	// Odd offsets carry nothing
	always_ff @(posedge clk_sys) begin
		if (code_wr && !code.addr[0])
			gg_code.words[cheat_slot(code.addr[3:0])] <= code.data;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			gg_valid <= 1'b0;
			gg_reset <= 1'b0;
		end else begin
			gg_valid <= code_wr && code.addr[3:0] == 4'd14; // Record complete
			gg_reset <= code_wr && code.addr == '0;         // New code list
		end
	end
endmodule

/* cart_loader_top.sv */
// Cartridge loader top level with download split, ROM pacing, region, quirks and cheats
`timescale 1ns/1ps
`include "cart_defs.svh"

module cart_loader_top import cheat_pkg::*; (
	input  logic clk_sys,
	input  logic RESET,
	input  logic ioctl_download,
	input  logic [7:0] ioctl_index,
	input  logic ioctl_wr,
	input  logic [`CART_ADDR_W-1:0] ioctl_addr,
	input  logic [`CART_DATA_W-1:0] ioctl_data,
	output logic ioctl_wait,
	output logic rom_wr,
	input  logic rom_wrack,
	output logic [`CART_ADDR_W-2:0] rom_addr,
	output logic [`CART_DATA_W-1:0] rom_wdata,
	output logic [`CART_ADDR_W-1:0] rom_sz,
	input  logic [1:0] region_mode,
	input  logic [1:0] region_priority,
	output logic [1:0] region_req,
	output logic region_set,
	output logic [7:0] quirks,
	output logic gun_type,
	output logic [7:0] gun_delay,
	output logic [31:0] gg_flags,
	output logic [31:0] gg_address,
	output logic [31:0] gg_compare,
	output logic [31:0] gg_replace,
	output logic gg_valid,
	output logic gg_reset
);
	dl_if cart_bus();
	dl_if code_bus();

	logic dl_start;
	logic dl_end;
	logic hdr_j;
	logic hdr_u;
	logic hdr_e;
	logic hdr_ready;
	cheat_code_u gg_code;

	//////////////////////////////
	// Download side
	//////////////////////////////

	dl_demux u_demux (
		.clk_sys(clk_sys), .RESET(RESET),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
		.cart(cart_bus), .code(code_bus),
		.dl_start(dl_start), .dl_end(dl_end)
	);

	rom_write_pacer u_pacer (
		.clk_sys(clk_sys), .RESET(RESET), .cart(cart_bus), .dl_end(dl_end),
		.rom_wrack(rom_wrack), .rom_wr(rom_wr), .ioctl_wait(ioctl_wait),
		.rom_addr(rom_addr), .rom_wdata(rom_wdata), .rom_sz(rom_sz)
	);

	//////////////////////////////
	// Header and core setup
	//////////////////////////////

	header_sniffer u_sniffer (
		.clk_sys(clk_sys), .cart(cart_bus), .dl_start(dl_start), .dl_end(dl_end),
		.hdr_j(hdr_j), .hdr_u(hdr_u), .hdr_e(hdr_e), .hdr_ready(hdr_ready)
	);

	region_select u_region (
		.clk_sys(clk_sys), .RESET(RESET),
		.hdr_j(hdr_j), .hdr_u(hdr_u), .hdr_e(hdr_e), .hdr_ready(hdr_ready),
		.index(cart_bus.index), .region_mode(region_mode),
		.region_priority(region_priority),
		.region_req(region_req), .region_set(region_set)
	);

	cart_quirk_regs u_quirks (
		.clk_sys(clk_sys), .RESET(RESET), .cart(cart_bus), .dl_start(dl_start),
		.quirks(quirks), .gun_type(gun_type), .gun_delay(gun_delay)
	);

	cheat_loader u_cheats (
		.clk_sys(clk_sys), .RESET(RESET), .code(code_bus),
		.gg_code(gg_code), .gg_valid(gg_valid), .gg_reset(gg_reset)
	);

	// Field view of the cheat record
	assign gg_flags = gg_code.fields.flags;
	assign gg_address = gg_code.fields.address;
	assign gg_compare = gg_code.fields.compare;
	assign gg_replace = gg_code.fields.replace;
endmodule

/* tb_cart_loader.sv */
// Trace-driven testbench for the cartridge loader with a ROM acknowledge model
`timescale 1ns/1ps
`include "cart_defs.svh"

module tb_cart_loader;
	localparam int WAIT_LIMIT = 8; // Longest ROM delay plus margin

	logic clk_sys;
	logic RESET;
	logic ioctl_download;
	logic [7:0] ioctl_index;
	logic ioctl_wr;
	logic [`CART_ADDR_W-1:0] ioctl_addr;
	logic [`CART_DATA_W-1:0] ioctl_data;
	logic ioctl_wait;
	logic rom_wr;
	logic rom_wrack;
	logic [`CART_ADDR_W-2:0] rom_addr;
	logic [`CART_DATA_W-1:0] rom_wdata;
	logic [`CART_ADDR_W-1:0] rom_sz;
	logic [1:0] region_mode;
	logic [1:0] region_priority;
	logic [1:0] region_req;
	logic region_set;
	logic [7:0] quirks;
	logic gun_type;
	logic [7:0] gun_delay;
	logic [31:0] gg_flags;
	logic [31:0] gg_address;
	logic [31:0] gg_compare;
	logic [31:0] gg_replace;
	logic gg_valid;
	logic gg_reset;

	int fd;
	int rc;
	int i;
	int ack_delay;
	int cart_writes = 0;
	int toggles = 0;
	int valid_pulses = 0;
	int reset_pulses = 0;
	logic rom_wr_q = 1'b0;
	string cmd;
	string name;
	string line;
	logic [7:0] index;
	logic [1:0] mode;
	logic [1:0] prio;
	logic [`CART_ADDR_W-1:0] addr;
	logic [`CART_DATA_W-1:0] data;
	logic [7:0] count;
	logic [63:0] value;
	logic [63:0] actual;

	cart_loader_top dut (.*);

	always #2 clk_sys = ~clk_sys;

	//////////////////////////////
	// ROM memory acknowledge model
	//////////////////////////////

	initial begin
		ack_delay = $urandom(32'h1189); // Seed for the delay sequence
		forever begin
			@(negedge clk_sys);
			if (!RESET && rom_wr !== rom_wrack) begin
				ack_delay = $urandom % 4 + 1; // 1 to 4 cycles
				repeat (ack_delay) @(negedge clk_sys);
				rom_wrack = rom_wr;
			end
		end
	end

	// Toggles and strobes, sampled away from the active edge
	always @(negedge clk_sys) begin
		if (!RESET) begin
			if (rom_wr !== rom_wr_q)
				toggles++;
			if (gg_valid)
				valid_pulses++;
			if (gg_reset)
				reset_pulses++;
		end
		rom_wr_q = rom_wr;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string test, input logic [63:0] expected,
			input logic [63:0] observed);
		if (observed !== expected)
			abort_run($sformatf("error: %s expected %0h actual %0h", test, expected, observed));
	endtask

	task automatic wait_host_free(input string what);
		int cycles;
		cycles = 0;
		while (ioctl_wait) begin
			@(negedge clk_sys);
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_run({"timeout: ioctl_wait stayed high ", what});
		end
	endtask

	task automatic cart_write(input logic [`CART_ADDR_W-1:0] a, input logic [15:0] d);
		wait_host_free("before a cart write");
		ioctl_addr = a;
		ioctl_data = d;
		ioctl_wr = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0; // Address and data stay on the bus
		cart_writes++;
		check_value("ioctl_wait_rise", 1, ioctl_wait);
		check_value("rom_wdata", {d[7:0], d[15:8]}, rom_wdata);
		check_value("rom_addr", a >> 1, rom_addr);
		wait_host_free("after the ROM acknowledge");
	endtask

	task automatic code_write(input logic [`CART_ADDR_W-1:0] a, input logic [15:0] d);
		ioctl_addr = a;
		ioctl_data = d;
		ioctl_wr = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		@(negedge clk_sys); // Let a strobe be counted
	endtask

	task automatic begin_download(input logic [7:0] idx, input logic [1:0] m,
			input logic [1:0] p);
		ioctl_index = idx;
		region_mode = m;
		region_priority = p;
		ioctl_download = 1'b1;
		repeat (3) @(negedge clk_sys); // Start pulse and its clear
	endtask

	task automatic end_download();
		ioctl_download = 1'b0;
		repeat (3) @(negedge clk_sys); // End pulse, then size capture
		check_value("rom_wr_toggles", cart_writes, toggles);
	endtask

	task automatic read_observed(input string n, output logic [63:0] v);
		if (n == "rom_sz") v = rom_sz;
		else if (n == "region_req") v = region_req;
		else if (n == "region_set") v = region_set;
		else if (n == "quirks") v = quirks;
		else if (n == "gun_type") v = gun_type;
		else if (n == "gun_delay") v = gun_delay;
		else if (n == "gg_flags") v = gg_flags;
		else if (n == "gg_address") v = gg_address;
		else if (n == "gg_compare") v = gg_compare;
		else if (n == "gg_replace") v = gg_replace;
		else if (n == "gg_valid_pulses") v = valid_pulses;
		else if (n == "gg_reset_pulses") v = reset_pulses;
		else abort_run({"trace asks for an unknown output ", n});
	endtask

	//////////////////////////////
	// Trace player
	//////////////////////////////

	initial begin
		clk_sys = 1'b0;
		RESET = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_data = '0;
		rom_wrack = 1'b0;
		region_mode = 2'd0;
		region_priority = 2'd0;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET = 1'b0;
		fd = $fopen("cart_trace.txt", "r");
		if (fd == 0)
			abort_run("could not open the trace file cart_trace.txt");
		while ($fscanf(fd, "%s", cmd) == 1) begin
			if (cmd == "#") begin
				rc = $fgets(line, fd);
			end else if (cmd == "B") begin
				rc = $fscanf(fd, "%h %h %h", index, mode, prio);
				if (rc != 3)
					abort_run("trace download line is incomplete");
				begin_download(index, mode, prio);
			end else if (cmd == "C" || cmd == "G") begin
				rc = $fscanf(fd, "%h %h", addr, count);
				if (rc != 2)
					abort_run("trace write line is incomplete");
				for (i = 0; i < count; i++) begin
					rc = $fscanf(fd, "%h", data);
					if (rc != 1)
						abort_run("trace write line has too few data words");
					if (cmd == "C")
						cart_write(addr + 2 * i, data);
					else
						code_write(addr + 2 * i, data);
				end
			end else if (cmd == "E") begin
				end_download();
			end else if (cmd == "X") begin
				rc = $fscanf(fd, "%s %h", name, value);
				if (rc != 2)
					abort_run("trace expect line is incomplete");
				read_observed(name, actual);
				check_value(name, value, actual);
			end else begin
				abort_run({"trace holds an unknown command ", cmd});
			end
		end
		$fclose(fd);
		$display("Simulation passed");
		$finish;
	end
endmodule

/* flist.f */
+incdir+.
cart_pkg.sv
cheat_pkg.sv
dl_if.sv
dl_demux.sv
rom_write_pacer.sv
header_sniffer.sv
region_select.sv
cart_quirk_regs.sv
cheat_loader.sv
cart_loader_top.sv
tb_cart_loader.sv

/* cart_trace.txt */
# Columns: B index mode prio | C addr n data.. | G addr n data.. | E | X name value
# All numbers hex, successive data words go to addr, addr+2 and so on
X gun_delay 2C
X gg_valid_pulses 0
# EEPROM title, header letters J and E, priority 1
B 01 1 1
C 182 6 4D00 2D4B 3231 3531 0020 0000
C 1F0 2 4A45 2020
C 200 1 0000
X quirks 02
X gun_type 0
X gun_delay 2C
X region_req 2
X region_set 1
E
X rom_sz 200
# Light-gun title, no header letters, priority 3
B 02 1 3
X quirks 00
C 182 6 5400 392D 3035 3639 002D 0000
C 1F0 2 2020 0000
C 200 1 0000
C 3FE 1 ABCD
X gun_type 1
X gun_delay 34
X region_req 0
X region_set 1
E
X rom_sz 3FE
# File extension index 10xxxxxx
B 81 0 0
C 200 1 1234
X region_req 2
X region_set 1
E
# One cheat record on the code index
B FF 0 0
G 0 8 0001 0000 1234 00FF ABCD 0000 9876 0000
X gg_valid_pulses 1
X gg_reset_pulses 1
X gg_flags 00000001
X gg_address 00FF1234
X gg_compare 0000ABCD
X gg_replace 00009876
E
